//--- hdl/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Reduced video mode, one pixel per pixclk
`define H_ACTIVE    304
`define H_FRONT     8
`define H_SYNC      16
`define H_BACK      8
`define H_TOTAL     (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE    176
`define V_FRONT     2
`define V_SYNC      2
`define V_BACK      4
`define V_TOTAL     (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define X_BITS      9   // Holds 0..335
`define Y_BITS      8   // Holds 0..183

// Map geometry
`define TILE_SHIFT  4   // 16x16 pixel tiles
`define MAP_ROWS    11
`define MAP_COLS    19
`define MAP_DEPTH   209

// Bomb timing in frames
`define BOMB_FRAMES 8
`define FIRE_FRAMES 4

`define INIT_ROW    1
`define INIT_COL    1

`endif

//--- hdl/game_pkg.sv
`include "game_defines.svh"

package game_pkg;

  typedef enum logic [1:0] {
    EMPTY,
    WALL,
    BOMB,
    FIRE
  } tile_e;

  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
  } dir_t;

  typedef logic [3:0] row_t;
  typedef logic [4:0] col_t;
  typedef logic [7:0] addr_t;

  // Row-major tile index
  function automatic addr_t to_addr(row_t r, col_t c);
    return addr_t'(r) * addr_t'(`MAP_COLS) + addr_t'(c);
  endfunction

  // Border tiles and even/even pillars are walls
  function automatic logic layout_wall(int r, int c);
    return (r == 0) || (r == `MAP_ROWS - 1) || (c == 0) || (c == `MAP_COLS - 1) ||
           ((r % 2 == 0) && (c % 2 == 0));
  endfunction

  function automatic logic addr_is_wall(addr_t a);
    int r;
    int c;
    r = int'(a) / `MAP_COLS;
    c = int'(a) % `MAP_COLS;
    return layout_wall(r, c);
  endfunction

endpackage

//--- hdl/video_if.sv
`include "game_defines.svh"

// Raster position plus timing flags, one set per pixclk
interface video_if;

  logic [`X_BITS-1:0] x;
  logic [`Y_BITS-1:0] y;
  logic               active;
  logic               hsync;    // Active low
  logic               vsync;    // Active low

  modport src (
    output x,
    output y,
    output active,
    output hsync,
    output vsync
  );

  modport sink (
    input x,
    input y,
    input active,
    input hsync,
    input vsync
  );

endinterface

//--- hdl/vga_timing.sv
`include "game_defines.svh"

module vga_timing (
  input  logic i_pixclk,
  input  logic i_reset,
  video_if.src vid,
  output logic o_frame_tick
);

  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END   = HS_START + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FRONT;
  localparam int VS_END   = VS_START + `V_SYNC;

  logic [`X_BITS-1:0] x_cnt;
  logic [`Y_BITS-1:0] y_cnt;
  logic               armed;

  always_ff @(posedge i_pixclk) begin
    if (i_reset) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (x_cnt == `X_BITS'(`H_TOTAL - 1)) begin
      x_cnt <= '0;
      if (y_cnt == `Y_BITS'(`V_TOTAL - 1)) begin
        y_cnt <= '0;
      end else begin
        y_cnt <= y_cnt + 1'b1;
      end
    end else begin
      x_cnt <= x_cnt + 1'b1;
    end
  end

  assign vid.x      = x_cnt;
  assign vid.y      = y_cnt;
  assign vid.active = (x_cnt < `H_ACTIVE) && (y_cnt < `V_ACTIVE);
  assign vid.hsync  = ~((x_cnt >= HS_START) && (x_cnt < HS_END));
  assign vid.vsync  = ~((y_cnt >= VS_START) && (y_cnt < VS_END));

  // The frame that starts at reset release gives no tick,
  // so the map sweep is long done before anything moves
  always_ff @(posedge i_pixclk) begin
    if (i_reset) begin
      armed        <= 1'b0;
      o_frame_tick <= 1'b0;
    end else begin
      armed        <= 1'b1;
      o_frame_tick <= armed && (x_cnt == '0) && (y_cnt == '0);
    end
  end

endmodule

//--- hdl/player_controller.sv
`include "game_defines.svh"

module player_controller (
  input  logic            i_pixclk,
  input  logic            i_reset,
  input  logic            i_tick,
  input  game_pkg::dir_t  i_dir,
  output game_pkg::addr_t o_rd_addr,
  input  game_pkg::tile_e i_rd_data,
  output game_pkg::row_t  o_row,
  output game_pkg::col_t  o_col
);

  game_pkg::dir_t dir_q;      // Direction sampled on the tick
  logic           step1;      // Target lookup this cycle
  logic           step2;      // Tile data arriving this cycle
  game_pkg::row_t tgt_row;
  game_pkg::col_t tgt_col;
  game_pkg::row_t tgt_row_q;
  game_pkg::col_t tgt_col_q;

  // Priority up, down, left, right
  always_comb begin
    tgt_row = o_row;
    tgt_col = o_col;
    if (step1) begin
      if (dir_q.up) begin
        tgt_row = o_row - 1'b1;
      end else if (dir_q.down) begin
        tgt_row = o_row + 1'b1;
      end else if (dir_q.left) begin
        tgt_col = o_col - 1'b1;
      end else if (dir_q.right) begin
        tgt_col = o_col + 1'b1;
      end
    end
  end

  // Read port 1 sees the target address in the cycle after the tick
  assign o_rd_addr = game_pkg::to_addr(tgt_row, tgt_col);

  always_ff @(posedge i_pixclk) begin
    if (i_tick) begin
      dir_q <= i_dir;
    end
    tgt_row_q <= tgt_row;
    tgt_col_q <= tgt_col;
  end

  always_ff @(posedge i_pixclk) begin
    if (i_reset) begin
      step1 <= 1'b0;
      step2 <= 1'b0;
      o_row <= game_pkg::row_t'(`INIT_ROW);
      o_col <= game_pkg::col_t'(`INIT_COL);
    end else begin
      step1 <= i_tick && (|i_dir);  // Idle frames need no lookup
      step2 <= step1;
      if (step2 && (i_rd_data != game_pkg::WALL) && (i_rd_data != game_pkg::BOMB)) begin
        o_row <= tgt_row_q;
        o_col <= tgt_col_q;
      end
    end
  end

endmodule

//--- hdl/bomb_logic.sv
`include "game_defines.svh"

module bomb_logic (
  input  logic            i_pixclk,
  input  logic            i_reset,
  input  logic            i_tick,
  input  logic            i_place,
  input  game_pkg::row_t  i_row,
  input  game_pkg::col_t  i_col,
  output logic            o_wr_en,
  output game_pkg::addr_t o_wr_addr,
  output game_pkg::tile_e o_wr_data,
  output logic [3:0]      o_countdown,
  output logic            o_exploding
);

  typedef enum logic [2:0] {
    IDLE,
    ARMED,
    BLAST_WRITE,
    FIRE,
    CLEAR_WRITE
  } state_e;

  state_e          state;
  logic [2:0]      idx;         // Cross tile being written
  logic [3:0]      fire_cnt;
  game_pkg::row_t  bomb_row;
  game_pkg::col_t  bomb_col;
  game_pkg::row_t  cross_row;
  game_pkg::col_t  cross_col;
  game_pkg::addr_t wr_addr_nxt;
  game_pkg::tile_e wr_data_nxt;

  // Centre first, then up, down, left, right
  always_comb begin
    cross_row = bomb_row;
    cross_col = bomb_col;
    case (idx)
      3'd1:    cross_row = bomb_row - 1'b1;
      3'd2:    cross_row = bomb_row + 1'b1;
      3'd3:    cross_col = bomb_col - 1'b1;
      3'd4:    cross_col = bomb_col + 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    if (state == IDLE) begin
      wr_addr_nxt = game_pkg::to_addr(i_row, i_col);
      wr_data_nxt = game_pkg::BOMB;
    end else begin
      wr_addr_nxt = game_pkg::to_addr(cross_row, cross_col);
      wr_data_nxt = (state == CLEAR_WRITE) ? game_pkg::EMPTY : game_pkg::FIRE;
    end
  end

  always_ff @(posedge i_pixclk) begin
    o_wr_addr <= wr_addr_nxt;
    o_wr_data <= wr_data_nxt;
    if ((state == IDLE) && i_tick && i_place) begin
      bomb_row <= i_row;
      bomb_col <= i_col;
    end
  end

  always_ff @(posedge i_pixclk) begin
    if (i_reset) begin
      state       <= IDLE;
      idx         <= '0;
      fire_cnt    <= '0;
      o_countdown <= '0;
      o_wr_en     <= 1'b0;
    end else begin
      o_wr_en <= 1'b0;
      case (state)
        IDLE: if (i_tick && i_place) begin
          state       <= ARMED;
          o_countdown <= 4'(`BOMB_FRAMES);
          o_wr_en     <= 1'b1;            // Drop the bomb tile
        end
        ARMED: if (i_tick) begin
          o_countdown <= o_countdown - 1'b1;
          if (o_countdown == 4'd1) begin
            state <= BLAST_WRITE;
            idx   <= '0;
          end
        end
        BLAST_WRITE: begin
          o_wr_en <= 1'b1;
          idx     <= idx + 1'b1;
          if (idx == 3'd4) begin
            state    <= FIRE;
            idx      <= '0;
            fire_cnt <= 4'(`FIRE_FRAMES);
          end
        end
        FIRE: if (i_tick) begin
          fire_cnt <= fire_cnt - 1'b1;
          if (fire_cnt == 4'd1) state <= CLEAR_WRITE;
        end
        CLEAR_WRITE: begin
          o_wr_en <= 1'b1;
          idx     <= idx + 1'b1;
          if (idx == 3'd4) begin
            state <= IDLE;
            idx   <= '0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign o_exploding = (state == FIRE);

endmodule

//--- hdl/map_mem.sv
`include "game_defines.svh"

module map_mem (
  input  logic            i_pixclk,
  input  logic            i_reset,
  input  game_pkg::addr_t i_rd1_addr,
  output game_pkg::tile_e o_rd1_data,
  input  game_pkg::addr_t i_rd2_addr,
  output game_pkg::tile_e o_rd2_data,
  input  logic            i_wr_en,
  input  game_pkg::addr_t i_wr_addr,
  input  game_pkg::tile_e i_wr_data
);

  game_pkg::tile_e mem [`MAP_DEPTH];
  logic            sweeping;
  game_pkg::addr_t sweep_addr;

  // Layout rebuild, one tile per cycle from address 0
  always_ff @(posedge i_pixclk) begin
    if (i_reset) begin
      sweeping   <= 1'b1;
      sweep_addr <= '0;
    end else if (sweeping) begin
      sweep_addr <= sweep_addr + 1'b1;
      if (sweep_addr == game_pkg::addr_t'(`MAP_DEPTH - 1)) sweeping <= 1'b0;
    end
  end

  always_ff @(posedge i_pixclk) begin
    if (sweeping) begin
      mem[sweep_addr] <= game_pkg::addr_is_wall(sweep_addr) ? game_pkg::WALL
                                                            : game_pkg::EMPTY;
    end else if (i_wr_en && !game_pkg::addr_is_wall(i_wr_addr)) begin
      mem[i_wr_addr] <= i_wr_data;    // Walls stay intact
    end
    o_rd1_data <= mem[i_rd1_addr];
    o_rd2_data <= mem[i_rd2_addr];
  end

endmodule

//--- hdl/tile_renderer.sv
`include "game_defines.svh"

module tile_renderer (
  input  logic            i_pixclk,
  input  logic            i_reset,
  video_if.sink           vid,
  input  game_pkg::row_t  i_player_row,
  input  game_pkg::col_t  i_player_col,
  output game_pkg::addr_t o_rd_addr,
  input  game_pkg::tile_e i_rd_data,
  output logic [3:0]      o_r,
  output logic [3:0]      o_g,
  output logic [3:0]      o_b,
  output logic            o_hsync,
  output logic            o_vsync
);

  game_pkg::row_t pix_row;
  game_pkg::col_t pix_col;
  logic           active_d1;
  logic           player_d1;
  logic           hsync_d1;
  logic           vsync_d1;
  logic [11:0]    rgb;

  assign pix_row = game_pkg::row_t'(vid.y >> `TILE_SHIFT);
  assign pix_col = game_pkg::col_t'(vid.x >> `TILE_SHIFT);

  // Blanking coordinates fall off the map, so park the address at 0
  assign o_rd_addr = vid.active ? game_pkg::to_addr(pix_row, pix_col) : '0;

  // Stage 1 follows the map read
  always_ff @(posedge i_pixclk) begin
    if (i_reset) begin
      active_d1 <= 1'b0;
      player_d1 <= 1'b0;
      hsync_d1  <= 1'b1;
      vsync_d1  <= 1'b1;
    end else begin
      active_d1 <= vid.active;
      player_d1 <= (pix_row == i_player_row) && (pix_col == i_player_col);
      hsync_d1  <= vid.hsync;
      vsync_d1  <= vid.vsync;
    end
  end

  always_comb begin
    if (!active_d1) begin
      rgb = 12'h000;
    end else if (player_d1) begin
      rgb = 12'hFF0;                  // Player drawn over its tile
    end else begin
      case (i_rd_data)
        game_pkg::WALL: rgb = 12'h888;
        game_pkg::BOMB: rgb = 12'hF00;
        game_pkg::FIRE: rgb = 12'hF80;
        default:        rgb = 12'h040;
      endcase
    end
  end

  // Stage 2 registers color and syncs together
  always_ff @(posedge i_pixclk) begin
    if (i_reset) begin
      {o_r, o_g, o_b} <= 12'h000;
      o_hsync         <= 1'b1;
      o_vsync         <= 1'b1;
    end else begin
      {o_r, o_g, o_b} <= rgb;
      o_hsync         <= hsync_d1;
      o_vsync         <= vsync_d1;
    end
  end

endmodule

//--- hdl/game_top.sv
module game_top (
  input  logic           i_pixclk,
  input  logic           i_reset,
  input  logic           i_up,
  input  logic           i_down,
  input  logic           i_left,
  input  logic           i_right,
  input  logic           i_place_bomb,
  output logic [3:0]     o_pix_r,
  output logic [3:0]     o_pix_g,
  output logic [3:0]     o_pix_b,
  output logic           o_hsync,
  output logic           o_vsync,
  output game_pkg::row_t o_player_row,
  output game_pkg::col_t o_player_col,
  output logic [3:0]     o_countdown,
  output logic           o_exploding
);

  video_if vid ();

  logic            frame_tick;
  game_pkg::dir_t  dir;
  game_pkg::addr_t rd1_addr;
  game_pkg::tile_e rd1_data;
  game_pkg::addr_t rd2_addr;
  game_pkg::tile_e rd2_data;
  logic            wr_en;
  game_pkg::addr_t wr_addr;
  game_pkg::tile_e wr_data;

  assign dir = '{up: i_up, down: i_down, left: i_left, right: i_right};

  vga_timing u_timing (
    .i_pixclk     (i_pixclk),
    .i_reset      (i_reset),
    .vid          (vid.src),
    .o_frame_tick (frame_tick)
  );

  player_controller u_player (
    .i_pixclk  (i_pixclk),
    .i_reset   (i_reset),
    .i_tick    (frame_tick),
    .i_dir     (dir),
    .o_rd_addr (rd1_addr),
    .i_rd_data (rd1_data),
    .o_row     (o_player_row),
    .o_col     (o_player_col)
  );

  bomb_logic u_bomb (
    .i_pixclk    (i_pixclk),
    .i_reset     (i_reset),
    .i_tick      (frame_tick),
    .i_place     (i_place_bomb),
    .i_row       (o_player_row),   // Bomb goes under the player
    .i_col       (o_player_col),
    .o_wr_en     (wr_en),
    .o_wr_addr   (wr_addr),
    .o_wr_data   (wr_data),
    .o_countdown (o_countdown),
    .o_exploding (o_exploding)
  );

  map_mem u_map (
    .i_pixclk   (i_pixclk),
    .i_reset    (i_reset),
    .i_rd1_addr (rd1_addr),
    .o_rd1_data (rd1_data),
    .i_rd2_addr (rd2_addr),
    .o_rd2_data (rd2_data),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data)
  );

  tile_renderer u_render (
    .i_pixclk     (i_pixclk),
    .i_reset      (i_reset),
    .vid          (vid.sink),
    .i_player_row (o_player_row),
    .i_player_col (o_player_col),
    .o_rd_addr    (rd2_addr),
    .i_rd_data    (rd2_data),
    .o_r          (o_pix_r),
    .o_g          (o_pix_g),
    .o_b          (o_pix_b),
    .o_hsync      (o_hsync),
    .o_vsync      (o_vsync)
  );

endmodule

//--- tests/tb_clock.sv
module tb_clock (
  output logic o_pixclk,
  output logic o_reset
);

  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    o_pixclk = 1'b0;
    forever #20 o_pixclk = ~o_pixclk;   // 40 ns period
  end

  // Reset held for three rising edges, released on a falling edge
  initial begin
    o_reset = 1'b1;
    repeat (3) @(posedge o_pixclk);
    @(negedge o_pixclk);
    o_reset = 1'b0;
  end

endmodule

//--- tests/game_top_sva.sv
`include "game_defines.svh"

module game_top_sva (
  input logic       i_pixclk,
  input logic       i_reset,
  input logic       i_up,
  input logic       i_down,
  input logic       i_left,
  input logic       i_right,
  input logic       i_place_bomb,
  input logic       frame_tick,
  input logic [3:0] o_pix_r,
  input logic [3:0] o_pix_g,
  input logic [3:0] o_pix_b,
  input logic       o_hsync,
  input logic       o_vsync,
  input logic [3:0] o_player_row,
  input logic [4:0] o_player_col,
  input logic [3:0] o_countdown,
  input logic       o_exploding
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int HS_FALL_X = `H_ACTIVE + `H_FRONT;
  localparam int VS_FALL_Y = `V_ACTIVE + `V_FRONT;

  int         fail_count = 0;
  logic       rst_q;
  logic       hs_q, vs_q, h_ok, v_ok, fell_h, fell_v, active;
  int         px_q, py_q, px, py, pr, pc;
  int         h_since, h_low, v_since, v_low;
  logic [3:0] dir_cap;
  logic [3:0] cd_tick, cd_prev, cd_exp;
  logic       tick_q, ex_q, prev_ok, has_bomb, cleared, arm_q;
  int         prev_r, prev_c, bomb_r, bomb_c, fire_ticks, fire_left, tr, tc;
  logic       moved, move_ok, on_player, on_bomb, on_cross;
  logic [11:0] rgb;

  // Border or even/even tile, anything off the map counts as wall
  function automatic logic wall_at(int r, int c);
    return (r <= 0) || (r >= `MAP_ROWS - 1) || (c <= 0) || (c >= `MAP_COLS - 1) ||
           ((r % 2 == 0) && (c % 2 == 0));
  endfunction

  always_comb begin
    fell_h    = hs_q && !o_hsync;
    fell_v    = vs_q && !o_vsync;
    px        = fell_h ? HS_FALL_X : px_q;    // Output pixel coordinate
    py        = fell_v ? VS_FALL_Y : py_q;
    pr        = py >> `TILE_SHIFT;
    pc        = px >> `TILE_SHIFT;
    active    = h_ok && v_ok && (px < `H_ACTIVE) && (py < `V_ACTIVE);
    rgb       = {o_pix_r, o_pix_g, o_pix_b};
    on_player = (pr == int'(o_player_row)) && (pc == int'(o_player_col));
    on_bomb   = has_bomb && (pr == bomb_r) && (pc == bomb_c);
    on_cross  = has_bomb && (((pr == bomb_r) && (pc >= bomb_c - 1) && (pc <= bomb_c + 1)) ||
                             ((pc == bomb_c) && (pr >= bomb_r - 1) && (pr <= bomb_r + 1)));
  end

  // Countdown from the last value, the tick and an accepted placement
  always_comb begin
    if (arm_q) cd_exp = 4'(`BOMB_FRAMES);
    else if (tick_q && (cd_prev != 4'd0)) cd_exp = cd_prev - 4'd1;
    else cd_exp = cd_prev;
  end

  // Expected move from the position seen at the previous vsync fall
  always_comb begin
    tr = prev_r;
    tc = prev_c;
    if (dir_cap[3]) tr = prev_r - 1;
    else if (dir_cap[2]) tr = prev_r + 1;
    else if (dir_cap[1]) tc = prev_c - 1;
    else if (dir_cap[0]) tc = prev_c + 1;
    moved = (int'(o_player_row) != prev_r) || (int'(o_player_col) != prev_c);
    if (dir_cap == 4'b0) begin
      move_ok = !moved;
    end else if (moved) begin
      move_ok = (int'(o_player_row) == tr) && (int'(o_player_col) == tc);
    end else begin
      // Wall or live bomb ahead
      move_ok = wall_at(tr, tc) || ((cd_tick != 4'd0) && (tr == bomb_r) && (tc == bomb_c));
    end
  end

  always_ff @(posedge i_pixclk) begin
    rst_q <= i_reset;
    if (i_reset) begin
      hs_q     <= 1'b1;
      vs_q     <= 1'b1;
      h_ok     <= 1'b0;
      v_ok     <= 1'b0;
      px_q     <= 0;
      py_q     <= 0;
      h_since  <= 0;
      h_low    <= 0;
      v_since  <= 0;
      v_low    <= 0;
      dir_cap  <= '0;
      cd_tick  <= '0;
      cd_prev  <= '0;
      tick_q   <= 1'b0;
      ex_q     <= 1'b0;
      arm_q    <= 1'b0;
      prev_ok  <= 1'b0;
      has_bomb <= 1'b0;
      cleared  <= 1'b0;
      fire_ticks <= 0;
      fire_left  <= 0;
    end else begin
      hs_q    <= o_hsync;
      vs_q    <= o_vsync;
      h_ok    <= h_ok | fell_h;
      v_ok    <= v_ok | (fell_v && h_ok);
      px_q    <= (px == `H_TOTAL - 1) ? 0 : px + 1;
      py_q    <= (px == `H_TOTAL - 1) ? ((py == `V_TOTAL - 1) ? 0 : py + 1) : py;
      h_since <= fell_h ? 1 : h_since + 1;
      h_low   <= o_hsync ? 0 : h_low + 1;
      v_since <= fell_v ? 1 : v_since + 1;
      v_low   <= o_vsync ? 0 : v_low + 1;
      tick_q  <= frame_tick;
      cd_prev <= o_countdown;
      ex_q    <= o_exploding;
      arm_q   <= frame_tick && i_place_bomb && (o_countdown == 4'd0) && !o_exploding;
      if (frame_tick) begin
        dir_cap <= {i_up, i_down, i_left, i_right};
        cd_tick <= o_countdown;
      end
      if (fell_v) begin
        prev_r  <= int'(o_player_row);
        prev_c  <= int'(o_player_col);
        prev_ok <= 1'b1;
      end
      if (arm_q) begin
        bomb_r   <= int'(o_player_row);   // Player has not moved off yet
        bomb_c   <= int'(o_player_col);
        has_bomb <= 1'b1;
        cleared  <= 1'b0;
      end
      if (o_exploding && !ex_q) fire_ticks <= 0;
      else if (frame_tick && o_exploding) fire_ticks <= fire_ticks + 1;
      if ((cd_prev == 4'd1) && (o_countdown == 4'd0)) fire_left <= `FIRE_FRAMES;
      else if (frame_tick && (fire_left != 0)) fire_left <= fire_left - 1;
      if (ex_q && !o_exploding) cleared <= 1'b1;
    end
  end

  a_reset_idle: assert property (@(posedge i_pixclk) (rst_q && !i_reset) |->
      o_hsync && o_vsync && (rgb == 12'h000) && (o_countdown == 4'd0) && !o_exploding)
    else begin fail_count++; $error("Outputs not idle right after reset"); end

  a_hsync_period: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (fell_h && h_ok) |-> (h_since == `H_TOTAL))
    else begin fail_count++; $error("Error at %0t: hsync period %0d, expected %0d",
      $time, h_since, `H_TOTAL); end

  a_hsync_width: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (!hs_q && o_hsync && h_ok) |-> (h_low == `H_SYNC))
    else begin fail_count++; $error("Error at %0t: o_hsync low %0d, expected %0d",
      $time, h_low, `H_SYNC); end

  a_vsync_period: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (fell_v && v_ok) |-> (v_since == `H_TOTAL * `V_TOTAL))
    else begin fail_count++; $error("Error at %0t: vsync period %0d, expected %0d",
      $time, v_since, `H_TOTAL * `V_TOTAL); end

  a_vsync_width: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (!vs_q && o_vsync && v_ok) |-> (v_low == `H_TOTAL * `V_SYNC))
    else begin fail_count++; $error("Error at %0t: o_vsync low %0d, expected %0d",
      $time, v_low, `H_TOTAL * `V_SYNC); end

  a_blank: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (h_ok && v_ok && !active) |-> (rgb == 12'h000))
    else begin fail_count++; $error("Error at %0t: blanking rgb %h, expected 000", $time, rgb); end

  a_wall: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (active && !on_player && wall_at(pr, pc)) |-> (rgb == 12'h888))
    else begin fail_count++; $error("Error at %0t: wall rgb %h, expected 888", $time, rgb); end

  a_player: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (active && on_player) |-> (rgb == 12'hFF0))
    else begin fail_count++; $error("Error at %0t: player rgb %h, expected ff0", $time, rgb); end

  a_move: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (fell_v && prev_ok) |-> (move_ok && !wall_at(o_player_row, o_player_col)))
    else begin fail_count++; $error("Player moved from %0d,%0d to %0d,%0d against the rules",
      prev_r, prev_c, o_player_row, o_player_col); end

  a_countdown: assert property (@(posedge i_pixclk) disable iff (i_reset)
      o_countdown == cd_exp)
    else begin fail_count++; $error("Error at %0t: o_countdown %0d, expected %0d",
      $time, o_countdown, cd_exp); end

  a_fire_frames: assert property (@(posedge i_pixclk) disable iff (i_reset)
      frame_tick |-> (o_exploding == (fire_left != 0)))
    else begin fail_count++; $error("Error at %0t: o_exploding %0b on tick, expected %0b",
      $time, o_exploding, fire_left != 0); end

  a_fire_len: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (ex_q && !o_exploding) |-> (fire_ticks == `FIRE_FRAMES))
    else begin fail_count++; $error("Error at %0t: o_exploding lasted %0d frames, expected %0d",
      $time, fire_ticks, `FIRE_FRAMES); end

  a_bomb_red: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (active && !on_player && on_bomb && (o_countdown != 4'd0)) |-> (rgb == 12'hF00))
    else begin fail_count++; $error("Error at %0t: bomb rgb %h, expected f00", $time, rgb); end

  a_fire_color: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (active && !on_player && o_exploding && on_cross && !wall_at(pr, pc)) |->
      (rgb == 12'hF80))
    else begin fail_count++; $error("Error at %0t: fire rgb %h, expected f80", $time, rgb); end

  a_cleared: assert property (@(posedge i_pixclk) disable iff (i_reset)
      (active && !on_player && cleared && on_cross && !wall_at(pr, pc)) |->
      (rgb == 12'h040))
    else begin fail_count++; $error("Error at %0t: cleared rgb %h, expected 040", $time, rgb); end

endmodule

bind game_top game_top_sva u_sva (
  .i_pixclk     (i_pixclk),
  .i_reset      (i_reset),
  .i_up         (i_up),
  .i_down       (i_down),
  .i_left       (i_left),
  .i_right      (i_right),
  .i_place_bomb (i_place_bomb),
  .frame_tick   (frame_tick),
  .o_pix_r      (o_pix_r),
  .o_pix_g      (o_pix_g),
  .o_pix_b      (o_pix_b),
  .o_hsync      (o_hsync),
  .o_vsync      (o_vsync),
  .o_player_row (o_player_row),
  .o_player_col (o_player_col),
  .o_countdown  (o_countdown),
  .o_exploding  (o_exploding)
);

//--- tests/game_tb.sv
module game_tb;

  timeunit 1ns;
  timeprecision 1ns;

  logic       pixclk;
  logic       i_reset;
  logic       i_up, i_down, i_left, i_right, i_place_bomb;
  logic [3:0] o_pix_r, o_pix_g, o_pix_b;
  logic       o_hsync, o_vsync;
  logic [3:0] o_player_row;
  logic [4:0] o_player_col;
  logic [3:0] o_countdown;
  logic       o_exploding;
  int         tests_run;
  bit         timed_out;

  tb_clock u_clk (
    .o_pixclk (pixclk),
    .o_reset  (i_reset)
  );

  game_top UUT (
    .i_pixclk     (pixclk),
    .i_reset      (i_reset),
    .i_up         (i_up),
    .i_down       (i_down),
    .i_left       (i_left),
    .i_right      (i_right),
    .i_place_bomb (i_place_bomb),
    .o_pix_r      (o_pix_r),
    .o_pix_g      (o_pix_g),
    .o_pix_b      (o_pix_b),
    .o_hsync      (o_hsync),
    .o_vsync      (o_vsync),
    .o_player_row (o_player_row),
    .o_player_col (o_player_col),
    .o_countdown  (o_countdown),
    .o_exploding  (o_exploding)
  );

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (i_reset && !timed_out) begin
      @(negedge pixclk);
      cycles++;
      if (cycles > 100) begin
        timed_out = 1'b1;
        $display("Timeout: reset was never released");
      end
    end
  endtask

  // Ends on the falling edge after the n-th vsync fall
  task automatic wait_frames(input int n);
    int   seen;
    int   cycles;
    logic vs_prev;
    seen    = 0;
    cycles  = 0;
    vs_prev = o_vsync;
    while (!timed_out && (seen < n)) begin
      @(negedge pixclk);
      cycles++;
      if (vs_prev && !o_vsync) seen++;
      vs_prev = o_vsync;
      if (cycles > n * 70000) begin
        timed_out = 1'b1;
        $display("Timeout: vsync fell only %0d of %0d times", seen, n);
      end
    end
  endtask

  task automatic hold_dir(input logic [3:0] d, input int frames);
    {i_up, i_down, i_left, i_right} = d;   // Up, down, left, right
    wait_frames(frames);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("Test %0d (%s) finished, assertion failures so far: %0d",
             tests_run, name, UUT.u_sva.fail_count);
  endtask

  initial begin
    i_up         = 1'b0;
    i_down       = 1'b0;
    i_left       = 1'b0;
    i_right      = 1'b0;
    i_place_bomb = 1'b0;
    tests_run    = 0;
    timed_out    = 1'b0;
    void'($urandom(32'ha906));

    wait_reset_release();
    wait_frames(3);
    finish_test("sync timing");
    wait_frames(1);
    finish_test("layout and blanking");

    // Push into the border, then check the priority order
    hold_dir(4'b1000, 2);
    hold_dir(4'b0010, 2);
    hold_dir(4'b0001, 3);
    hold_dir(4'b0101, 2);   // Down wins, pillar below
    hold_dir(4'b0011, 2);   // Left wins
    hold_dir(4'b1001, 2);   // Up wins, border above
    finish_test("directed moves");

    repeat (24) begin
      hold_dir(4'($urandom % 16), 1);
    end
    hold_dir(4'b0000, 1);
    finish_test("random walk and player drawing");

    i_place_bomb = 1'b1;
    wait_frames(1);
    i_place_bomb = 1'b0;
    // Step off the bomb toward a tile that is never a wall
    if (!o_player_row[0]) begin
      hold_dir(4'b1000, 1);
    end else if (o_player_col == 5'd17) begin
      hold_dir(4'b0010, 1);
    end else begin
      hold_dir(4'b0001, 1);
    end
    hold_dir(4'b0000, 1);
    i_place_bomb = 1'b1;    // Ignored while armed
    wait_frames(2);
    i_place_bomb = 1'b0;
    wait_frames(14);
    finish_test("bomb countdown, fire and cleanup");
    finish_test("second placement ignored");

    $display("Tests run: %0d, assertion failures: %0d, timeout: %0d",
             tests_run, UUT.u_sva.fail_count, timed_out);
    if ((UUT.u_sva.fail_count == 0) && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+hdl
hdl/game_pkg.sv
hdl/video_if.sv
hdl/vga_timing.sv
hdl/player_controller.sv
hdl/bomb_logic.sv
hdl/map_mem.sv
hdl/tile_renderer.sv
hdl/game_top.sv
tests/tb_clock.sv
tests/game_top_sva.sv
tests/game_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the game testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module game_tb -o game_sim > build.log 2>&1 \
  && ./obj_dir/game_sim > sim.log 2>&1 \
  ; grep -q "No errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }
